/* Makefile */
# Verilator build and run of the ITCM controller testbench

TOP := tb_itcm_ctrl

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -f src.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -q "Everything OK"

clean:
	rm -rf obj_dir

/* hw/itcm_bus_pkg.sv */
// ITCM bus package
// Requester and operation encodings, the command structs of the fetch
// and load/store ports, and the request bundle toward the SRAM

package itcm_bus_pkg;

  import itcm_cfg_pkg::*;

  // Tag carried with each command so the response finds its way back
  typedef enum logic {
    SRC_IFU = 1'b0,
    SRC_LSU = 1'b1
  } itcm_src_e;

  typedef enum logic {
    OP_WRITE = 1'b0,
    OP_READ  = 1'b1
  } itcm_op_e;

  ////////////////////////////////////////////////////////////////////
  // Command payloads
  typedef struct packed {
    itcm_addr_t addr;
    itcm_op_e   op;
    itcm_word_t wdata;
    itcm_wmsk_t wmask;   // One bit per byte lane
  } itcm_cmd_t;

  typedef struct packed {
    itcm_addr_t addr;
    itcm_op_e   op;
    lsu_word_t  wdata;
    lsu_wmsk_t  wmask;
  } lsu_cmd_t;

  // Single-port SRAM request, read data returns one cycle later
  typedef struct packed {
    logic       cs;
    logic       we;
    ram_addr_t  addr;
    itcm_wmsk_t wem;
    itcm_word_t din;
  } ram_req_t;

endpackage

/* hw/itcm_cfg_pkg.sv */
// ITCM configuration package
// Sizes of the memory array and of the fetch and load/store ports,
// and the width types built from them

package itcm_cfg_pkg;

  ////////////////////////////////////////////////////////////////////
  // Memory geometry
  localparam int ITCM_ADDR_W = 16;                  // Byte address
  localparam int ITCM_DATA_W = 64;                  // RAM word
  localparam int ITCM_WMSK_W = ITCM_DATA_W / 8;
  localparam int ITCM_AW_LSB = 3;                   // 8 bytes per RAM word
  localparam int ITCM_RAM_AW = ITCM_ADDR_W - ITCM_AW_LSB;

  // Load/store port is half the RAM width
  localparam int LSU_DATA_W = 32;
  localparam int LSU_WMSK_W = LSU_DATA_W / 8;

  ////////////////////////////////////////////////////////////////////
  // Width types
  typedef logic [ITCM_ADDR_W-1:0] itcm_addr_t;
  typedef logic [ITCM_DATA_W-1:0] itcm_word_t;
  typedef logic [ITCM_WMSK_W-1:0] itcm_wmsk_t;
  typedef logic [ITCM_RAM_AW-1:0] ram_addr_t;

  typedef logic [LSU_DATA_W-1:0] lsu_word_t;
  typedef logic [LSU_WMSK_W-1:0] lsu_wmsk_t;

endpackage

/* hw/itcm_ctrl.sv */
// Instruction TCM controller, top level
// Shares one 64-bit single-port SRAM between the fetch port and a
// 32-bit load/store port, load/store having priority

module itcm_ctrl (
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  // Fetch port
  input  logic                     i_ifu_cmd_valid,
  output logic                     o_ifu_cmd_ready,
  input  itcm_bus_pkg::itcm_cmd_t  i_ifu_cmd,
  output logic                     o_ifu_rsp_valid,
  input  logic                     i_ifu_rsp_ready,
  output itcm_cfg_pkg::itcm_word_t o_ifu_rsp_rdata,
  output logic                     o_ifu_holdup,
  // Load/store port
  input  logic                     i_lsu_cmd_valid,
  output logic                     o_lsu_cmd_ready,
  input  itcm_bus_pkg::lsu_cmd_t   i_lsu_cmd,
  output logic                     o_lsu_rsp_valid,
  input  logic                     i_lsu_rsp_ready,
  output itcm_cfg_pkg::lsu_word_t  o_lsu_rsp_rdata,
  // SRAM
  output itcm_bus_pkg::ram_req_t   o_ram_req,
  input  itcm_cfg_pkg::itcm_word_t i_ram_dout,
  output logic                     o_itcm_active
);

  import itcm_cfg_pkg::*;
  import itcm_bus_pkg::*;

  // Widened load/store channel
  logic       lsu_cmd_valid;
  logic       lsu_cmd_ready;
  itcm_cmd_t  lsu_cmd;
  logic       lsu_rsp_valid;
  logic       lsu_rsp_ready;
  itcm_word_t lsu_rsp_rdata;

  // Arbiter to SRAM controller
  logic       sram_cmd_valid;
  logic       sram_cmd_ready;
  itcm_cmd_t  sram_cmd;
  itcm_src_e  sram_cmd_src;
  logic       sram_rsp_valid;
  logic       sram_rsp_ready;
  itcm_word_t sram_rsp_rdata;
  itcm_src_e  sram_rsp_src;
  logic       sram_busy;

  itcm_lsu_widen u_lsu_widen (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_cmd_valid (i_lsu_cmd_valid),
    .o_cmd_ready (o_lsu_cmd_ready),
    .i_cmd       (i_lsu_cmd),
    .o_rsp_valid (o_lsu_rsp_valid),
    .i_rsp_ready (i_lsu_rsp_ready),
    .o_rsp_rdata (o_lsu_rsp_rdata),
    .o_cmd_valid (lsu_cmd_valid),
    .i_cmd_ready (lsu_cmd_ready),
    .o_cmd       (lsu_cmd),
    .i_rsp_valid (lsu_rsp_valid),
    .o_rsp_ready (lsu_rsp_ready),
    .i_rsp_rdata (lsu_rsp_rdata)
  );

  itcm_port_arbiter u_port_arbiter (
    .i_clk           (i_clk),
    .i_rst_n         (i_rst_n),
    .i_ifu_cmd_valid (i_ifu_cmd_valid),
    .o_ifu_cmd_ready (o_ifu_cmd_ready),
    .i_ifu_cmd       (i_ifu_cmd),
    .o_ifu_rsp_valid (o_ifu_rsp_valid),
    .i_ifu_rsp_ready (i_ifu_rsp_ready),
    .o_ifu_rsp_rdata (o_ifu_rsp_rdata),
    .o_ifu_holdup    (o_ifu_holdup),
    .i_lsu_cmd_valid (lsu_cmd_valid),
    .o_lsu_cmd_ready (lsu_cmd_ready),
    .i_lsu_cmd       (lsu_cmd),
    .o_lsu_rsp_valid (lsu_rsp_valid),
    .i_lsu_rsp_ready (lsu_rsp_ready),
    .o_lsu_rsp_rdata (lsu_rsp_rdata),
    .o_cmd_valid     (sram_cmd_valid),
    .i_cmd_ready     (sram_cmd_ready),
    .o_cmd           (sram_cmd),
    .o_cmd_src       (sram_cmd_src),
    .i_rsp_valid     (sram_rsp_valid),
    .o_rsp_ready     (sram_rsp_ready),
    .i_rsp_rdata     (sram_rsp_rdata),
    .i_rsp_src       (sram_rsp_src),
    .i_busy          (sram_busy),
    .o_itcm_active   (o_itcm_active)
  );

  itcm_sram_ctrl u_sram_ctrl (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_cmd_valid (sram_cmd_valid),
    .o_cmd_ready (sram_cmd_ready),
    .i_cmd       (sram_cmd),
    .i_cmd_src   (sram_cmd_src),
    .o_rsp_valid (sram_rsp_valid),
    .i_rsp_ready (sram_rsp_ready),
    .o_rsp_rdata (sram_rsp_rdata),
    .o_rsp_src   (sram_rsp_src),
    .o_ram_req   (o_ram_req),
    .i_ram_dout  (i_ram_dout),
    .o_busy      (sram_busy)
  );

endmodule

/* hw/itcm_lsu_widen.sv */
// Load/store port width converter
// Places 32-bit load/store commands on the 64-bit ITCM bus with a
// lane-shifted byte mask, and returns the matching half of the read data

module itcm_lsu_widen (
  input  logic                    i_clk,
  input  logic                    i_rst_n,
  // Narrow load/store side
  input  logic                    i_cmd_valid,
  output logic                    o_cmd_ready,
  input  itcm_bus_pkg::lsu_cmd_t  i_cmd,
  output logic                    o_rsp_valid,
  input  logic                    i_rsp_ready,
  output itcm_cfg_pkg::lsu_word_t o_rsp_rdata,
  // Wide side toward the arbiter
  output logic                    o_cmd_valid,
  input  logic                    i_cmd_ready,
  output itcm_bus_pkg::itcm_cmd_t o_cmd,
  input  logic                    i_rsp_valid,
  output logic                    o_rsp_ready,
  input  itcm_cfg_pkg::itcm_word_t i_rsp_rdata
);

  import itcm_cfg_pkg::*;

  logic cmd_lane;   // 1 selects upper 32 bits
  logic lane_q;

  assign cmd_lane = i_cmd.addr[ITCM_AW_LSB-1];

  // Handshakes pass straight through
  assign o_cmd_valid = i_cmd_valid;
  assign o_cmd_ready = i_cmd_ready;
  assign o_rsp_valid = i_rsp_valid;
  assign o_rsp_ready = i_rsp_ready;

  always_comb begin
    o_cmd.addr  = i_cmd.addr;
    o_cmd.op    = i_cmd.op;
    o_cmd.wdata = {i_cmd.wdata, i_cmd.wdata};   // Same data in both halves
    if (cmd_lane) begin
      o_cmd.wmask = {i_cmd.wmask, {LSU_WMSK_W{1'b0}}};
    end else begin
      o_cmd.wmask = {{LSU_WMSK_W{1'b0}}, i_cmd.wmask};
    end
  end

  // Lane of the command in flight, used on the way back
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      lane_q <= 1'b0;
    end else if (i_cmd_valid && i_cmd_ready) begin
      lane_q <= cmd_lane;
    end
  end

  assign o_rsp_rdata = lane_q ? i_rsp_rdata[ITCM_DATA_W-1:LSU_DATA_W]
                              : i_rsp_rdata[LSU_DATA_W-1:0];

endmodule

/* hw/itcm_port_arbiter.sv */
// ITCM port arbiter
// Fixed priority between the load/store and fetch ports, load/store
// first. Routes responses by the returned tag and keeps the fetch
// hold-up flag and the activity output

module itcm_port_arbiter (
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  // Fetch port
  input  logic                     i_ifu_cmd_valid,
  output logic                     o_ifu_cmd_ready,
  input  itcm_bus_pkg::itcm_cmd_t  i_ifu_cmd,
  output logic                     o_ifu_rsp_valid,
  input  logic                     i_ifu_rsp_ready,
  output itcm_cfg_pkg::itcm_word_t o_ifu_rsp_rdata,
  output logic                     o_ifu_holdup,
  // Load/store port, already widened
  input  logic                     i_lsu_cmd_valid,
  output logic                     o_lsu_cmd_ready,
  input  itcm_bus_pkg::itcm_cmd_t  i_lsu_cmd,
  output logic                     o_lsu_rsp_valid,
  input  logic                     i_lsu_rsp_ready,
  output itcm_cfg_pkg::itcm_word_t o_lsu_rsp_rdata,
  // SRAM controller side
  output logic                     o_cmd_valid,
  input  logic                     i_cmd_ready,
  output itcm_bus_pkg::itcm_cmd_t  o_cmd,
  output itcm_bus_pkg::itcm_src_e  o_cmd_src,
  input  logic                     i_rsp_valid,
  output logic                     o_rsp_ready,
  input  itcm_cfg_pkg::itcm_word_t i_rsp_rdata,
  input  itcm_bus_pkg::itcm_src_e  i_rsp_src,
  input  logic                     i_busy,
  output logic                     o_itcm_active
);

  import itcm_bus_pkg::*;

  logic rsp_is_ifu;
  logic ifu_acc;
  logic lsu_acc;
  logic holdup_q;

  //////////////////////////////////////////////////////////////////////
  // Command selection

  // Fetch only gets the RAM when load/store is idle
  assign o_ifu_cmd_ready = i_cmd_ready & ~i_lsu_cmd_valid;
  assign o_lsu_cmd_ready = i_cmd_ready;

  assign o_cmd_valid = i_lsu_cmd_valid | i_ifu_cmd_valid;
  assign o_cmd       = i_lsu_cmd_valid ? i_lsu_cmd : i_ifu_cmd;
  assign o_cmd_src   = i_lsu_cmd_valid ? SRC_LSU : SRC_IFU;

  //////////////////////////////////////////////////////////////////////
  // Response routing

  assign rsp_is_ifu = (i_rsp_src == SRC_IFU);

  assign o_ifu_rsp_valid = i_rsp_valid & rsp_is_ifu;
  assign o_lsu_rsp_valid = i_rsp_valid & ~rsp_is_ifu;
  assign o_rsp_ready     = rsp_is_ifu ? i_ifu_rsp_ready : i_lsu_rsp_ready;
  assign o_ifu_rsp_rdata = i_rsp_rdata;   // Shared data, valid qualifies it
  assign o_lsu_rsp_rdata = i_rsp_rdata;

  //////////////////////////////////////////////////////////////////////
  // Hold-up flag

  // RAM output still has the last fetched word until load/store touches it
  assign ifu_acc = i_ifu_cmd_valid & o_ifu_cmd_ready;
  assign lsu_acc = i_lsu_cmd_valid & o_lsu_cmd_ready;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      holdup_q <= 1'b0;
    end else if (lsu_acc) begin
      holdup_q <= 1'b0;
    end else if (ifu_acc) begin
      holdup_q <= 1'b1;
    end
  end

  assign o_ifu_holdup = holdup_q;

  assign o_itcm_active = i_ifu_cmd_valid | i_lsu_cmd_valid | i_busy;

endmodule

/* hw/itcm_sram_ctrl.sv */
// ITCM SRAM controller
// Issues one request at a time to the single-port SRAM and holds the
// read data in a response register until the requester takes it

module itcm_sram_ctrl (
  input  logic                     i_clk,
  input  logic                     i_rst_n,
  // Command in
  input  logic                     i_cmd_valid,
  output logic                     o_cmd_ready,
  input  itcm_bus_pkg::itcm_cmd_t  i_cmd,
  input  itcm_bus_pkg::itcm_src_e  i_cmd_src,
  // Response out
  output logic                     o_rsp_valid,
  input  logic                     i_rsp_ready,
  output itcm_cfg_pkg::itcm_word_t o_rsp_rdata,
  output itcm_bus_pkg::itcm_src_e  o_rsp_src,
  // SRAM
  output itcm_bus_pkg::ram_req_t   o_ram_req,
  input  itcm_cfg_pkg::itcm_word_t i_ram_dout,
  output logic                     o_busy
);

  import itcm_cfg_pkg::*;
  import itcm_bus_pkg::*;

  logic      cmd_fire;
  logic      rsp_fire;
  logic      pending_q;   // Response waiting
  logic      first_q;     // RAM output valid this cycle
  itcm_src_e src_q;
  itcm_word_t rdata_q;

  // New command only if no response is stuck
  assign o_cmd_ready = ~pending_q | i_rsp_ready;
  assign cmd_fire    = i_cmd_valid & o_cmd_ready;
  assign rsp_fire    = pending_q & i_rsp_ready;

  //////////////////////////////////////////////////////////////////////
  // SRAM request
  always_comb begin
    o_ram_req.cs   = cmd_fire;
    o_ram_req.we   = (i_cmd.op == OP_WRITE);
    o_ram_req.addr = i_cmd.addr[ITCM_ADDR_W-1:ITCM_AW_LSB];
    o_ram_req.wem  = i_cmd.wmask;
    o_ram_req.din  = i_cmd.wdata;
  end

  //////////////////////////////////////////////////////////////////////
  // Response state
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      pending_q <= 1'b0;
      first_q   <= 1'b0;
    end else begin
      first_q <= cmd_fire;
      if (cmd_fire) begin
        pending_q <= 1'b1;
      end else if (rsp_fire) begin
        pending_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (cmd_fire) begin
      src_q <= i_cmd_src;
    end
    if (first_q) begin
      rdata_q <= i_ram_dout;   // Keep the word once the RAM moves on
    end
  end

  assign o_rsp_valid = pending_q;
  assign o_rsp_rdata = first_q ? i_ram_dout : rdata_q;
  assign o_rsp_src   = src_q;
  assign o_busy      = pending_q;

endmodule

/* sim/itcm_ram_model.sv */
// Behavioral ITCM SRAM
// 64-bit single-port array with byte write enables, read data
// appears one cycle after the request

module itcm_ram_model (
  input  logic                     i_clk,
  input  itcm_bus_pkg::ram_req_t   i_req,
  output itcm_cfg_pkg::itcm_word_t o_dout
);

  import itcm_cfg_pkg::*;

  itcm_word_t mem [0:(1<<ITCM_RAM_AW)-1];

  always_ff @(posedge i_clk) begin
    if (i_req.cs) begin
      if (i_req.we) begin
        for (int b = 0; b < ITCM_WMSK_W; b++) begin
          if (i_req.wem[b]) begin
            mem[i_req.addr][8*b +: 8] <= i_req.din[8*b +: 8];
          end
        end
      end else begin
        o_dout <= mem[i_req.addr];   // Held until the next read
      end
    end
  end

endmodule

/* sim/tb_itcm_ctrl.sv */
// Testbench for the ITCM controller
// Runs a table of fetch and load/store steps against a behavioral SRAM
// and checks read data, priority, hold-up, back-pressure and activity

module tb_itcm_ctrl;

  import itcm_cfg_pkg::*;
  import itcm_bus_pkg::*;

  localparam int WAIT_LIMIT = 40;
  localparam int NUM_STEPS  = 12;

  typedef struct packed {
    itcm_src_e  port;
    itcm_op_e   op;
    itcm_addr_t addr;
    itcm_wmsk_t mask;   // Low 4 bits only on load/store
    logic       bp;     // Hold response ready low for a while
    logic       dual;   // Fetch read of the same word raised together
  } step_t;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        ifu_cmd_valid;
  logic        ifu_cmd_ready;
  logic        ifu_rsp_valid;
  logic        ifu_rsp_ready;
  logic        ifu_holdup;
  itcm_cmd_t   ifu_cmd;
  itcm_word_t  ifu_rsp_rdata;
  logic        lsu_cmd_valid;
  logic        lsu_cmd_ready;
  logic        lsu_rsp_valid;
  logic        lsu_rsp_ready;
  lsu_cmd_t    lsu_cmd;
  lsu_word_t   lsu_rsp_rdata;
  ram_req_t    ram_req;
  itcm_word_t  ram_dout;
  logic        itcm_active;

  step_t       steps [NUM_STEPS];
  itcm_word_t  sb_mem [0:(1<<ITCM_RAM_AW)-1];   // Expected RAM contents
  logic [31:0] lfsr = 32'h1413_5c4b;

  always #50 clk = ~clk;

  itcm_ctrl u_dut (
    .i_clk           (clk),
    .i_rst_n         (rst_n),
    .i_ifu_cmd_valid (ifu_cmd_valid),
    .o_ifu_cmd_ready (ifu_cmd_ready),
    .i_ifu_cmd       (ifu_cmd),
    .o_ifu_rsp_valid (ifu_rsp_valid),
    .i_ifu_rsp_ready (ifu_rsp_ready),
    .o_ifu_rsp_rdata (ifu_rsp_rdata),
    .o_ifu_holdup    (ifu_holdup),
    .i_lsu_cmd_valid (lsu_cmd_valid),
    .o_lsu_cmd_ready (lsu_cmd_ready),
    .i_lsu_cmd       (lsu_cmd),
    .o_lsu_rsp_valid (lsu_rsp_valid),
    .i_lsu_rsp_ready (lsu_rsp_ready),
    .o_lsu_rsp_rdata (lsu_rsp_rdata),
    .o_ram_req       (ram_req),
    .i_ram_dout      (ram_dout),
    .o_itcm_active   (itcm_active)
  );

  itcm_ram_model u_ram (
    .i_clk  (clk),
    .i_req  (ram_req),
    .o_dout (ram_dout)
  );

  ////////////////////////////////////////////////////////////////////
  // Checks

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_word(input itcm_word_t got, input itcm_word_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("ERROR at time %0t: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_lsu(input lsu_word_t got, input lsu_word_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("ERROR at time %0t: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic compare_rsp(input itcm_src_e port, input itcm_word_t got,
                             input itcm_word_t exp, input string what);
    if (port == SRC_LSU) begin
      check_lsu(got[LSU_DATA_W-1:0], exp[LSU_DATA_W-1:0], what);
    end else begin
      check_word(got, exp, what);
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Stimulus helpers

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_bits(input int n, output itcm_word_t val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[ITCM_DATA_W-2:0], lfsr[0]};
    end
  endtask

  task automatic sb_write(input step_t st, input itcm_word_t data);
    ram_addr_t a;
    int        base;
    a    = st.addr[ITCM_ADDR_W-1:ITCM_AW_LSB];
    base = (st.port == SRC_LSU && st.addr[2]) ? 4 : 0;   // Upper lane bytes 4..7
    for (int b = 0; b < ITCM_WMSK_W; b++) begin
      if (st.mask[b]) begin
        sb_mem[a][8*(b+base) +: 8] = data[8*b +: 8];
      end
    end
  endtask

  function automatic itcm_word_t expect_read(input step_t st);
    itcm_word_t w;
    w = sb_mem[st.addr[ITCM_ADDR_W-1:ITCM_AW_LSB]];
    if (st.port == SRC_IFU) begin
      return w;
    end
    return st.addr[2] ? {32'h0, w[63:32]} : {32'h0, w[31:0]};
  endfunction

  function automatic logic rsp_valid(input itcm_src_e port);
    return (port == SRC_LSU) ? lsu_rsp_valid : ifu_rsp_valid;
  endfunction

  function automatic itcm_word_t rsp_data(input itcm_src_e port);
    return (port == SRC_LSU) ? {32'h0, lsu_rsp_rdata} : ifu_rsp_rdata;
  endfunction

  task automatic set_rsp_ready(input itcm_src_e port, input logic v);
    if (port == SRC_LSU) lsu_rsp_ready <= v;
    else ifu_rsp_ready <= v;
  endtask

  task automatic drive_cmd(input step_t st, input itcm_word_t data);
    if (st.port == SRC_LSU) begin
      lsu_cmd_valid <= 1'b1;
      lsu_cmd <= '{addr: st.addr, op: st.op, wdata: data[LSU_DATA_W-1:0],
                   wmask: st.mask[LSU_WMSK_W-1:0]};
    end else begin
      ifu_cmd_valid <= 1'b1;
      ifu_cmd <= '{addr: st.addr, op: st.op, wdata: data, wmask: st.mask};
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Handshake waits

  task automatic wait_cmd_accept(input itcm_src_e port);
    int   cycles;
    logic rdy;
    cycles = 0;
    rdy    = 1'b0;
    while (!rdy) begin
      @(posedge clk);
      check_lsu(lsu_word_t'(itcm_active), 32'd1, "activity with command valid");
      rdy = (port == SRC_LSU) ? lsu_cmd_ready : ifu_cmd_ready;
      cycles++;
      if (!rdy && cycles > WAIT_LIMIT) abort_run("Timed out waiting for command ready");
    end
    if (port == SRC_LSU) lsu_cmd_valid <= 1'b0;
    else ifu_cmd_valid <= 1'b0;
  endtask

  task automatic wait_rsp(input itcm_src_e port, output itcm_word_t data);
    int cycles;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      if (!rsp_valid(port) && cycles > WAIT_LIMIT) begin
        abort_run("Timed out waiting for response valid");
      end
    end while (!rsp_valid(port));
    data = rsp_data(port);
  endtask

  // Response stalled for 2 to 5 cycles while nothing else enters the RAM
  task automatic hold_rsp(input itcm_src_e port, input itcm_word_t held);
    itcm_word_t r;
    itcm_word_t got;
    int         n;
    rand_bits(2, r);
    n = 2 + int'(r[1:0]);
    for (int k = 0; k < n; k++) begin
      @(posedge clk);
      check_lsu(lsu_word_t'(rsp_valid(port)), 32'd1, "response valid under back-pressure");
      compare_rsp(port, rsp_data(port), held, "held response data");
      check_lsu(lsu_word_t'(ifu_cmd_ready), 32'd0, "fetch ready under back-pressure");
      check_lsu(lsu_word_t'(lsu_cmd_ready), 32'd0, "load/store ready under back-pressure");
      check_lsu(lsu_word_t'(itcm_active), 32'd1, "activity with response pending");
    end
    set_rsp_ready(port, 1'b1);
    wait_rsp(port, got);
    compare_rsp(port, got, held, "response data on release");
  endtask

  // Load/store and fetch raised together so the fetch reads the word just written
  task automatic run_dual(input step_t st);
    step_t      fetch;
    itcm_word_t got;
    int         cycles;
    logic       lsu_done;
    logic       ifu_done;
    fetch         = st;
    fetch.port    = SRC_IFU;
    ifu_cmd_valid <= 1'b1;
    ifu_cmd       <= '{addr: st.addr, op: OP_READ, wdata: '0, wmask: '0};
    cycles   = 0;
    lsu_done = 1'b0;
    while (!lsu_done) begin
      @(posedge clk);
      check_lsu(lsu_word_t'(ifu_cmd_ready), 32'd0, "fetch ready with load/store valid");
      lsu_done = lsu_cmd_ready;
      cycles++;
      if (!lsu_done && cycles > WAIT_LIMIT) abort_run("Timed out waiting for load/store ready");
    end
    lsu_cmd_valid <= 1'b0;
    cycles   = 0;
    lsu_done = 1'b0;
    ifu_done = 1'b0;
    while (!(lsu_done && ifu_done)) begin
      @(posedge clk);
      if (lsu_rsp_valid) lsu_done = 1'b1;
      if (ifu_cmd_ready && !ifu_done) begin
        ifu_done = 1'b1;
        ifu_cmd_valid <= 1'b0;
      end
      cycles++;
      if (cycles > WAIT_LIMIT) abort_run("Timed out waiting for the queued fetch");
    end
    wait_rsp(SRC_IFU, got);
    check_word(got, expect_read(fetch), "fetch after load/store write");
  endtask

  task automatic run_step(input step_t st);
    itcm_word_t wdata;
    itcm_word_t got;
    wdata = '0;
    if (st.op == OP_WRITE) begin
      rand_bits((st.port == SRC_LSU) ? LSU_DATA_W : ITCM_DATA_W, wdata);
      sb_write(st, wdata);
    end
    @(posedge clk);
    check_lsu(lsu_word_t'(itcm_active), 32'd0, "activity while idle");
    drive_cmd(st, wdata);
    if (st.bp) set_rsp_ready(st.port, 1'b0);
    if (st.dual) begin
      run_dual(st);
    end else begin
      wait_cmd_accept(st.port);
      wait_rsp(st.port, got);
      if (st.op == OP_READ) compare_rsp(st.port, got, expect_read(st), "read data");
      if (st.bp) hold_rsp(st.port, (st.op == OP_READ) ? expect_read(st) : got);
    end
    check_lsu(lsu_word_t'(ifu_holdup), lsu_word_t'(st.dual || (st.port == SRC_IFU)),
              "hold-up flag");
  endtask

  task automatic fill_table();
    steps[0]  = '{SRC_IFU, OP_WRITE, 16'h0100, 8'hFF, 1'b0, 1'b0};
    steps[1]  = '{SRC_IFU, OP_WRITE, 16'h0208, 8'hFF, 1'b0, 1'b0};
    steps[2]  = '{SRC_IFU, OP_READ,  16'h0100, 8'h00, 1'b0, 1'b0};
    steps[3]  = '{SRC_LSU, OP_WRITE, 16'h0208, 8'h03, 1'b0, 1'b0};   // Lower lane
    steps[4]  = '{SRC_LSU, OP_WRITE, 16'h020C, 8'h0C, 1'b0, 1'b0};   // Upper lane
    steps[5]  = '{SRC_IFU, OP_READ,  16'h0208, 8'h00, 1'b0, 1'b0};
    steps[6]  = '{SRC_LSU, OP_READ,  16'h020C, 8'h00, 1'b0, 1'b0};
    steps[7]  = '{SRC_LSU, OP_READ,  16'h0104, 8'h00, 1'b1, 1'b0};
    steps[8]  = '{SRC_IFU, OP_READ,  16'h0208, 8'h00, 1'b1, 1'b0};
    steps[9]  = '{SRC_LSU, OP_WRITE, 16'h0100, 8'h0F, 1'b0, 1'b1};
    steps[10] = '{SRC_LSU, OP_READ,  16'h0100, 8'h00, 1'b0, 1'b0};
    steps[11] = '{SRC_IFU, OP_READ,  16'h0100, 8'h00, 1'b0, 1'b0};
  endtask

  initial begin
    rst_n         <= 1'b0;
    ifu_cmd_valid <= 1'b0;
    ifu_cmd       <= '0;
    ifu_rsp_ready <= 1'b1;
    lsu_cmd_valid <= 1'b0;
    lsu_cmd       <= '0;
    lsu_rsp_ready <= 1'b1;
    fill_table();
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    check_lsu(lsu_word_t'(ifu_holdup), 32'd0, "hold-up after reset");
    check_lsu(lsu_word_t'(ifu_rsp_valid), 32'd0, "fetch response valid after reset");
    check_lsu(lsu_word_t'(lsu_rsp_valid), 32'd0, "load/store response valid after reset");
    check_lsu(lsu_word_t'(ram_req.cs), 32'd0, "RAM select after reset");
    for (int i = 0; i < NUM_STEPS; i++) begin
      run_step(steps[i]);
    end
    $display("Everything OK");
    $finish;
  end

endmodule

/* src.f */
hw/itcm_cfg_pkg.sv
hw/itcm_bus_pkg.sv
hw/itcm_lsu_widen.sv
hw/itcm_port_arbiter.sv
hw/itcm_sram_ctrl.sv
hw/itcm_ctrl.sv
sim/itcm_ram_model.sv
sim/tb_itcm_ctrl.sv
